// File: project.f
+incdir+dv
hw/fifo_pkg.sv
hw/fifo_occ_if.sv
hw/fifo_cfg_if.sv
hw/fifo_ptr_ctrl.sv
hw/fifo_flag_gen.sv
hw/fifo_csr.sv
hw/fifo_ram.sv
hw/fifo_top.sv
dv/tb_fifo_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the FIFO testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f project.f --top-module tb_fifo_top -Mdir obj_dir -o sim_fifo
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_fifo > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
   echo "no result line in sim.log"
   exit 1
fi
exit 0

// File: dv/tb_fifo_tasks.svh
/*
 * Wishbone classic bus tasks and typed compare tasks for tb_fifo_top
 * bus tasks start and end on a falling edge
 */
`ifndef TB_FIFO_TASKS_SVH
`define TB_FIFO_TASKS_SVH

// ----------------------------------------
// Wishbone classic master
// ----------------------------------------
task automatic wb_write(input fifo_pkg::wb_adr_t adr, input fifo_pkg::data_t dat);
   wb_cyc_i = 1'b1;
   wb_stb_i = 1'b1;
   wb_we_i  = 1'b1;
   wb_adr_i = adr;
   wb_dat_i = dat;
   @(negedge pos_clk);
   // no wait states expected, the global timeout catches a missing ack
   while (!wb_ack_o)
      @(negedge pos_clk);
   wb_cyc_i = 1'b0;
   wb_stb_i = 1'b0;
   wb_we_i  = 1'b0;
endtask

task automatic wb_read(input fifo_pkg::wb_adr_t adr, output fifo_pkg::data_t dat);
   wb_cyc_i = 1'b1;
   wb_stb_i = 1'b1;
   wb_we_i  = 1'b0;
   wb_adr_i = adr;
   @(negedge pos_clk);
   while (!wb_ack_o)
      @(negedge pos_clk);
   // data valid while ack is high
   dat      = wb_dat_o;
   wb_cyc_i = 1'b0;
   wb_stb_i = 1'b0;
endtask

// ----------------------------------------
// compare tasks, one per result type
// ----------------------------------------
task automatic check_data(input string name, input fifo_pkg::data_t got,
                          input fifo_pkg::data_t exp);
   if (got !== exp) begin
      err_count++;
      $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
   end
endtask

task automatic check_level(input string name, input fifo_pkg::level_t got,
                           input fifo_pkg::level_t exp);
   if (got !== exp) begin
      err_count++;
      $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      err_count++;
      $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
   end
endtask

`endif

// File: dv/tb_fifo_top.sv
/*
 * testbench for fifo_top with default parameters
 * inputs change on the falling edge; model_step runs on the rising edge
 * and outputs are compared on the following falling edge
 */
`timescale 1ns/1ps

module tb_fifo_top;

   localparam int               DEPTH     = 1 << fifo_pkg::DEPTH_LOG2;
   localparam int               LW        = fifo_pkg::DEPTH_LOG2 + 1;
   localparam fifo_pkg::level_t DEPTH_LVL = fifo_pkg::level_t'(DEPTH);
   // planned cycles of the six tests, doubled for the limit
   localparam int PLAN_CYC    = 12 + 30 + 30 + 50 + 320 + 20;
   localparam int TIMEOUT_CYC = 2 * PLAN_CYC;

   logic pos_clk, aresetn, wr_req_i, rd_req_i, wb_cyc_i, wb_stb_i, wb_we_i;
   logic wack_o, full_o, afull_o, dvld_o, empty_o, aempty_o;
   logic overflow_o, underflow_o, wb_ack_o;
   fifo_pkg::data_t   wr_data_i, rd_data_o, wb_dat_i, wb_dat_o;
   fifo_pkg::level_t  level_o;
   fifo_pkg::wb_adr_t wb_adr_i;

   int   err_count = 0;
   int   n_tests   = 0;
   int   n_failed  = 0;
   int   cycles    = 0;
   logic checks_on = 1'b0;
   fifo_pkg::data_t sent[$];

   // model state and predicted outputs
   fifo_pkg::data_t  m_q[$];
   fifo_pkg::level_t m_level      = '0;
   fifo_pkg::level_t m_afull_lvl  = fifo_pkg::AFULL_RST;
   fifo_pkg::level_t m_aempty_lvl = fifo_pkg::AEMPTY_RST;
   logic m_err_ovf = 1'b0, m_err_udf = 1'b0;
   logic exp_full = 1'b0, exp_empty = 1'b1, exp_afull = 1'b0, exp_aempty = 1'b1;
   logic exp_wack = 1'b0, exp_dvld = 1'b0, exp_ovf = 1'b0, exp_udf = 1'b0;
   logic exp_ack  = 1'b0;
   fifo_pkg::data_t exp_rd_data = '0;

   `include "tb_fifo_tasks.svh"

   fifo_top DUT (.*);

   initial begin
      pos_clk = 1'b0;
      forever #5 pos_clk = ~pos_clk;
   end

   // ----------------------------------------
   // reference model, one call per rising edge
   // ----------------------------------------
   function automatic void model_step(input logic wr, input logic rd,
      input fifo_pkg::data_t wdata, input logic cyc, input logic stb, input logic we,
      input fifo_pkg::wb_adr_t adr, input fifo_pkg::data_t dat);
      logic wr_acc;
      logic rd_acc;
      logic wb_req;
      logic wb_wr;
      wr_acc = wr && (m_level != DEPTH_LVL);
      rd_acc = rd && (m_level != '0);
      wb_req = cyc && stb && !exp_ack;
      wb_wr  = wb_req && we;
      // sticky bits take the pulse now on the outputs, pulse beats clear
      m_err_ovf = exp_ovf | (m_err_ovf & ~(wb_wr && adr == fifo_pkg::REG_ERR
                                           && dat[fifo_pkg::ERR_OVF]));
      m_err_udf = exp_udf | (m_err_udf & ~(wb_wr && adr == fifo_pkg::REG_ERR
                                           && dat[fifo_pkg::ERR_UDF]));
      exp_ovf  = wr && (m_level == DEPTH_LVL);
      exp_udf  = rd && (m_level == '0);
      exp_wack = wr_acc;
      exp_dvld = rd_acc;
      if (rd_acc)
         exp_rd_data = m_q.pop_front();
      if (wr_acc)
         m_q.push_back(wdata);
      if (wr_acc && !rd_acc)
         m_level = m_level + 1'b1;
      else if (rd_acc && !wr_acc)
         m_level = m_level - 1'b1;
      exp_full   = (m_level == DEPTH_LVL);
      exp_empty  = (m_level == '0);
      // thresholds written on this edge only count from the next one
      exp_afull  = (m_level >= m_afull_lvl);
      exp_aempty = (m_level <= m_aempty_lvl);
      exp_ack    = wb_req;
      if (wb_wr && adr == fifo_pkg::REG_AFULL)
         m_afull_lvl = dat[LW-1:0];
      if (wb_wr && adr == fifo_pkg::REG_AEMPTY)
         m_aempty_lvl = dat[LW-1:0];
   endfunction

   // model on the rising edge, compare half a cycle later
   always @(posedge pos_clk) begin
      if (checks_on) begin
         model_step(wr_req_i, rd_req_i, wr_data_i, wb_cyc_i, wb_stb_i, wb_we_i,
                    wb_adr_i, wb_dat_i);
         @(negedge pos_clk);
         check_level("level_o", level_o, m_level);
         check_flag("full_o", full_o, exp_full);
         check_flag("empty_o", empty_o, exp_empty);
         check_flag("afull_o", afull_o, exp_afull);
         check_flag("aempty_o", aempty_o, exp_aempty);
         check_flag("wack_o", wack_o, exp_wack);
         check_flag("dvld_o", dvld_o, exp_dvld);
         check_flag("overflow_o", overflow_o, exp_ovf);
         check_flag("underflow_o", underflow_o, exp_udf);
         check_flag("wb_ack_o", wb_ack_o, exp_ack);
         if (exp_dvld)
            check_data("rd_data_o", rd_data_o, exp_rd_data);
      end
   end

   // run limit
   always @(posedge pos_clk) begin
      cycles++;
      if (cycles > TIMEOUT_CYC) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic report_test(input string name, input int errs_before);
      n_tests++;
      if (err_count == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         n_failed++;
         $display("test %s: %0d mismatches", name, err_count - errs_before);
      end
   endtask

   // ----------------------------------------
   // tests
   // ----------------------------------------
   initial begin
      fifo_pkg::data_t d;
      int e;
      void'($urandom(35));
      {aresetn, wr_req_i, rd_req_i, wb_cyc_i, wb_stb_i, wb_we_i} = '0;
      wr_data_i = '0;
      wb_dat_i  = '0;
      wb_adr_i  = '0;
      repeat (2) @(posedge pos_clk);
      @(negedge pos_clk);
      aresetn   = 1'b1;
      checks_on = 1'b1;

      // 1: reset state and threshold defaults
      e = err_count;
      check_flag("empty_o", empty_o, 1'b1);
      check_flag("aempty_o", aempty_o, 1'b1);
      check_flag("full_o", full_o, 1'b0);
      check_flag("afull_o", afull_o, 1'b0);
      check_flag("wack_o", wack_o, 1'b0);
      check_flag("dvld_o", dvld_o, 1'b0);
      check_flag("overflow_o", overflow_o, 1'b0);
      check_flag("underflow_o", underflow_o, 1'b0);
      check_flag("wb_ack_o", wb_ack_o, 1'b0);
      check_level("level_o", level_o, '0);
      wb_read(fifo_pkg::REG_AFULL, d);
      check_data("reg_afull", d, fifo_pkg::data_t'(fifo_pkg::AFULL_RST));
      wb_read(fifo_pkg::REG_AEMPTY, d);
      check_data("reg_aempty", d, fifo_pkg::data_t'(fifo_pkg::AEMPTY_RST));
      report_test("reset", e);

      // 2: fill, then one write too many
      e = err_count;
      for (int i = 0; i < DEPTH; i++) begin
         wr_req_i  = 1'b1;
         wr_data_i = $urandom;
         sent.push_back(wr_data_i);
         @(negedge pos_clk);
         check_level("level_o", level_o, fifo_pkg::level_t'(i + 1));
         check_flag("afull_o", afull_o, fifo_pkg::level_t'(i + 1) >= fifo_pkg::AFULL_RST);
      end
      @(negedge pos_clk);
      wr_req_i = 1'b0;
      check_flag("overflow_o", overflow_o, 1'b1);
      check_level("level_o", level_o, DEPTH_LVL);
      @(negedge pos_clk);
      wb_read(fifo_pkg::REG_ERR, d);
      check_flag("err_ovf", d[fifo_pkg::ERR_OVF], 1'b1);
      report_test("fill", e);

      // 3: drain in order, then one read too many
      e = err_count;
      for (int i = 0; i < DEPTH; i++) begin
         rd_req_i = 1'b1;
         @(negedge pos_clk);
         check_flag("dvld_o", dvld_o, 1'b1);
         check_data("rd_data_o", rd_data_o, sent[i]);
         check_flag("aempty_o", aempty_o,
                    fifo_pkg::level_t'(DEPTH - i - 1) <= fifo_pkg::AEMPTY_RST);
      end
      @(negedge pos_clk);
      rd_req_i = 1'b0;
      check_flag("underflow_o", underflow_o, 1'b1);
      @(negedge pos_clk);
      wb_read(fifo_pkg::REG_ERR, d);
      check_flag("err_udf", d[fifo_pkg::ERR_UDF], 1'b1);
      report_test("drain", e);

      // 4: new thresholds, then a ramp up and down
      e = err_count;
      wb_write(fifo_pkg::REG_AFULL, 32'd6);
      wb_write(fifo_pkg::REG_AEMPTY, 32'd2);
      wb_read(fifo_pkg::REG_AFULL, d);
      check_data("reg_afull", d, 32'd6);
      wb_read(fifo_pkg::REG_AEMPTY, d);
      check_data("reg_aempty", d, 32'd2);
      wr_req_i = 1'b1;
      for (int i = 0; i < 8; i++) begin
         wr_data_i = $urandom;
         @(negedge pos_clk);
         check_flag("afull_o", afull_o, fifo_pkg::level_t'(i + 1) >= 5'd6);
         check_flag("aempty_o", aempty_o, fifo_pkg::level_t'(i + 1) <= 5'd2);
      end
      wr_req_i = 1'b0;
      rd_req_i = 1'b1;
      for (int i = 0; i < 8; i++) begin
         @(negedge pos_clk);
         check_flag("afull_o", afull_o, fifo_pkg::level_t'(7 - i) >= 5'd6);
         check_flag("aempty_o", aempty_o, fifo_pkg::level_t'(7 - i) <= 5'd2);
      end
      rd_req_i = 1'b0;
      report_test("thresholds", e);

      // 5: random traffic, write heavy then read heavy to hit both ends
      e = err_count;
      for (int i = 0; i < 300; i++) begin
         wr_req_i  = (i < 150) ? (($urandom % 4) != 0) : (($urandom % 4) == 0);
         rd_req_i  = (i < 150) ? (($urandom % 4) == 0) : (($urandom % 4) != 0);
         wr_data_i = $urandom;
         @(negedge pos_clk);
      end
      wr_req_i = 1'b0;
      rd_req_i = 1'b0;
      repeat (2) @(negedge pos_clk);
      report_test("random", e);

      // 6: clear sticky errors, status against the model
      e = err_count;
      wb_read(fifo_pkg::REG_ERR, d);
      check_flag("err_ovf", d[fifo_pkg::ERR_OVF], m_err_ovf);
      check_flag("err_udf", d[fifo_pkg::ERR_UDF], m_err_udf);
      check_data("reg_err", d, 32'h3);
      wb_write(fifo_pkg::REG_ERR, 32'h3);
      wb_read(fifo_pkg::REG_ERR, d);
      check_flag("err_ovf", d[fifo_pkg::ERR_OVF], m_err_ovf);
      check_flag("err_udf", d[fifo_pkg::ERR_UDF], m_err_udf);
      check_data("reg_err", d, 32'h0);
      wb_read(fifo_pkg::REG_STATUS, d);
      check_flag("st_full", d[fifo_pkg::ST_FULL], exp_full);
      check_flag("st_empty", d[fifo_pkg::ST_EMPTY], exp_empty);
      check_flag("st_afull", d[fifo_pkg::ST_AFULL], exp_afull);
      check_flag("st_aempty", d[fifo_pkg::ST_AEMPTY], exp_aempty);
      check_level("st_level", d[fifo_pkg::ST_LEVEL_LSB +: LW], m_level);
      report_test("err_clear", e);

      // last compare finishes before the summary
      checks_on = 1'b0;
      @(negedge pos_clk);
      $display("tests %0d, failed %0d, mismatches %0d", n_tests, n_failed, err_count);
      if (err_count == 0 && n_failed == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: hw/fifo_top.sv
/*
 * single clock FIFO with Wishbone register block
 * refused requests are dropped and pulse overflow or underflow
 */
`timescale 1ns/1ps

module fifo_top #(
   parameter int DATA_WIDTH = fifo_pkg::DATA_W,
   parameter int DEPTH_LOG2 = fifo_pkg::DEPTH_LOG2
) (
   input  logic              pos_clk,
   input  logic              aresetn,
   // write side
   input  logic              wr_req_i,
   input  fifo_pkg::data_t   wr_data_i,
   output logic              wack_o,
   output logic              full_o,
   output logic              afull_o,
   // read side
   input  logic              rd_req_i,
   output fifo_pkg::data_t   rd_data_o,
   output logic              dvld_o,
   output logic              empty_o,
   output logic              aempty_o,
   output fifo_pkg::level_t  level_o,
   output logic              overflow_o,
   output logic              underflow_o,
   // Wishbone slave
   input  logic              wb_cyc_i,
   input  logic              wb_stb_i,
   input  logic              wb_we_i,
   input  fifo_pkg::wb_adr_t wb_adr_i,
   input  fifo_pkg::data_t   wb_dat_i,
   output fifo_pkg::data_t   wb_dat_o,
   output logic              wb_ack_o
);

   fifo_occ_if occ_bus ();
   fifo_cfg_if cfg_bus ();

   logic            mem_we;
   logic            mem_re;
   fifo_pkg::addr_t mem_waddr;
   fifo_pkg::addr_t mem_raddr;

   fifo_ptr_ctrl #(.DEPTH_LOG2(DEPTH_LOG2)) u_ptr_ctrl (
      .pos_clk(pos_clk), .aresetn(aresetn),
      .wr_req_i(wr_req_i), .rd_req_i(rd_req_i), .occ(occ_bus.ctrl),
      .mem_we_o(mem_we), .mem_waddr_o(mem_waddr),
      .mem_re_o(mem_re), .mem_raddr_o(mem_raddr)
   );

   fifo_flag_gen u_flag_gen (
      .pos_clk(pos_clk), .aresetn(aresetn),
      .occ(occ_bus.flags), .cfg(cfg_bus.flags),
      .wack_o(wack_o), .overflow_o(overflow_o), .underflow_o(underflow_o),
      .afull_o(afull_o), .aempty_o(aempty_o)
   );

   fifo_csr #(.DEPTH_LOG2(DEPTH_LOG2)) u_csr (
      .pos_clk(pos_clk), .aresetn(aresetn),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .cfg(cfg_bus.csr)
   );

   fifo_ram #(.DATA_WIDTH(DATA_WIDTH), .DEPTH_LOG2(DEPTH_LOG2)) u_ram (
      .pos_clk(pos_clk), .aresetn(aresetn),
      .we_i(mem_we), .waddr_i(mem_waddr), .wdata_i(wr_data_i),
      .re_i(mem_re), .raddr_i(mem_raddr),
      .rdata_o(rd_data_o), .dvld_o(dvld_o)
   );

   // registered flags straight from the controller
   assign full_o  = occ_bus.full;
   assign empty_o = occ_bus.empty;
   assign level_o = occ_bus.level;

endmodule

// File: hw/fifo_ram.sv
/*
 * simple dual-port RAM, one cycle registered read
 * same-address read and write never occur, the controller rules it out
 */
`timescale 1ns/1ps

module fifo_ram #(
   parameter int DATA_WIDTH = fifo_pkg::DATA_W,
   parameter int DEPTH_LOG2 = fifo_pkg::DEPTH_LOG2
) (
   input  logic            pos_clk,
   input  logic            aresetn,
   input  logic            we_i,
   input  fifo_pkg::addr_t waddr_i,
   input  fifo_pkg::data_t wdata_i,
   input  logic            re_i,
   input  fifo_pkg::addr_t raddr_i,
   output fifo_pkg::data_t rdata_o,
   output logic            dvld_o
);

   logic [DATA_WIDTH-1:0] mem [1 << DEPTH_LOG2];
   fifo_pkg::data_t       rdata_r;
   logic                  dvld_r;

   // storage and read register
   always_ff @(posedge pos_clk) begin
      if (we_i)
         mem[waddr_i] <= wdata_i;
      if (re_i)
         rdata_r <= mem[raddr_i];
   end

   // strobe lines up with the registered word
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn)
         dvld_r <= 1'b0;
      else
         dvld_r <= re_i;
   end

   assign rdata_o = rdata_r;
   assign dvld_o  = dvld_r;

endmodule

// File: hw/fifo_csr.sv
/*
 * Wishbone classic slave, one ack per cycle, no wait states
 * REG_STATUS is read only; REG_ERR bits are write one to clear
 */
`timescale 1ns/1ps

module fifo_csr #(
   parameter int DEPTH_LOG2 = fifo_pkg::DEPTH_LOG2
) (
   input  logic              pos_clk,
   input  logic              aresetn,
   input  logic              wb_cyc_i,
   input  logic              wb_stb_i,
   input  logic              wb_we_i,
   input  fifo_pkg::wb_adr_t wb_adr_i,
   input  fifo_pkg::data_t   wb_dat_i,
   output fifo_pkg::data_t   wb_dat_o,
   output logic              wb_ack_o,
   fifo_cfg_if.csr           cfg
);

   logic             ack_r;
   logic             wb_req;
   logic             wb_wr;
   logic             clr_ovf;
   logic             clr_udf;
   fifo_pkg::level_t afull_lvl;
   fifo_pkg::level_t aempty_lvl;
   logic             err_ovf;
   logic             err_udf;
   fifo_pkg::data_t  status;
   fifo_pkg::data_t  rd_mux;
   fifo_pkg::data_t  dat_r;

   // ----------------------------------------
   // bus decode
   // ----------------------------------------
   // new cycle only while ack is low, so a held strobe acks once
   assign wb_req  = wb_cyc_i & wb_stb_i & ~ack_r;
   assign wb_wr   = wb_req & wb_we_i;
   assign clr_ovf = wb_wr && (wb_adr_i == fifo_pkg::REG_ERR) && wb_dat_i[fifo_pkg::ERR_OVF];
   assign clr_udf = wb_wr && (wb_adr_i == fifo_pkg::REG_ERR) && wb_dat_i[fifo_pkg::ERR_UDF];

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         ack_r      <= 1'b0;
         afull_lvl  <= fifo_pkg::AFULL_RST;
         aempty_lvl <= fifo_pkg::AEMPTY_RST;
         err_ovf    <= 1'b0;
         err_udf    <= 1'b0;
      end else begin
         ack_r <= wb_req;
         if (wb_wr && wb_adr_i == fifo_pkg::REG_AFULL)
            afull_lvl <= wb_dat_i[DEPTH_LOG2:0];
         if (wb_wr && wb_adr_i == fifo_pkg::REG_AEMPTY)
            aempty_lvl <= wb_dat_i[DEPTH_LOG2:0];
         // a pulse beats a clear in the same cycle
         err_ovf <= cfg.ovf_pulse | (err_ovf & ~clr_ovf);
         err_udf <= cfg.udf_pulse | (err_udf & ~clr_udf);
      end
   end

   // ----------------------------------------
   // read path
   // ----------------------------------------
   always_comb begin
      status                                            = '0;
      status[fifo_pkg::ST_FULL]                         = cfg.full;
      status[fifo_pkg::ST_EMPTY]                        = cfg.empty;
      status[fifo_pkg::ST_AFULL]                        = cfg.afull;
      status[fifo_pkg::ST_AEMPTY]                       = cfg.aempty;
      status[fifo_pkg::ST_LEVEL_LSB +: DEPTH_LOG2 + 1] = cfg.level;
   end

   always_comb begin
      rd_mux = '0;
      case (wb_adr_i)
         fifo_pkg::REG_AFULL:  rd_mux[DEPTH_LOG2:0] = afull_lvl;
         fifo_pkg::REG_AEMPTY: rd_mux[DEPTH_LOG2:0] = aempty_lvl;
         fifo_pkg::REG_STATUS: rd_mux = status;
         default: begin
            rd_mux[fifo_pkg::ERR_OVF] = err_ovf;
            rd_mux[fifo_pkg::ERR_UDF] = err_udf;
         end
      endcase
   end

   // captured with the ack, held until the next cycle
   always_ff @(posedge pos_clk) begin
      if (wb_req)
         dat_r <= rd_mux;
   end

   assign wb_dat_o        = dat_r;
   assign wb_ack_o        = ack_r;
   assign cfg.afull_level  = afull_lvl;
   assign cfg.aempty_level = aempty_lvl;

   a_ack_single : assert property (@(posedge pos_clk) disable iff (!aresetn)
      wb_ack_o |=> !wb_ack_o);

endmodule

// File: hw/fifo_flag_gen.sv
/*
 * almost flags, write ack and overflow/underflow pulses, all registered
 * a new threshold is used from the edge after it is written
 */
`timescale 1ns/1ps

module fifo_flag_gen (
   input  logic      pos_clk,
   input  logic      aresetn,
   fifo_occ_if.flags occ,
   fifo_cfg_if.flags cfg,
   output logic      wack_o,
   output logic      overflow_o,
   output logic      underflow_o,
   output logic      afull_o,
   output logic      aempty_o
);

   fifo_pkg::level_t level_nxt;
   logic             afull_r;
   logic             aempty_r;
   logic             wack_r;
   logic             ovf_r;
   logic             udf_r;

   // same next occupancy the controller registers
   always_comb begin
      case ({occ.wr_acc, occ.rd_acc})
         2'b10:   level_nxt = occ.level + 1'b1;
         2'b01:   level_nxt = occ.level - 1'b1;
         default: level_nxt = occ.level;
      endcase
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         afull_r  <= 1'b0;
         aempty_r <= 1'b1;
         wack_r   <= 1'b0;
         ovf_r    <= 1'b0;
         udf_r    <= 1'b0;
      end else begin
         afull_r  <= (level_nxt >= cfg.afull_level);
         aempty_r <= (level_nxt <= cfg.aempty_level);
         wack_r   <= occ.wr_acc;
         // request that met a blocking flag
         ovf_r    <= occ.wr_req & occ.full;
         udf_r    <= occ.rd_req & occ.empty;
      end
   end

   assign wack_o      = wack_r;
   assign overflow_o  = ovf_r;
   assign underflow_o = udf_r;
   assign afull_o     = afull_r;
   assign aempty_o    = aempty_r;

   // up to the register block
   assign cfg.afull     = afull_r;
   assign cfg.aempty    = aempty_r;
   assign cfg.ovf_pulse = ovf_r;
   assign cfg.udf_pulse = udf_r;
   assign cfg.full      = occ.full;
   assign cfg.empty     = occ.empty;
   assign cfg.level     = occ.level;

   // a refused write is never also acknowledged
   a_ovf_wack : assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(overflow_o && wack_o));

endmodule

// File: hw/fifo_ptr_ctrl.sv
/*
 * pointers and occupancy for a power-of-two deep sync FIFO
 * writes are refused while full and reads while empty; no wait handshake
 */
`timescale 1ns/1ps

module fifo_ptr_ctrl #(
   parameter int DEPTH_LOG2 = fifo_pkg::DEPTH_LOG2
) (
   input  logic            pos_clk,
   input  logic            aresetn,
   input  logic            wr_req_i,
   input  logic            rd_req_i,
   fifo_occ_if.ctrl        occ,
   output logic            mem_we_o,
   output fifo_pkg::addr_t mem_waddr_o,
   output logic            mem_re_o,
   output fifo_pkg::addr_t mem_raddr_o
);

   localparam fifo_pkg::level_t DEPTH = fifo_pkg::level_t'(1 << DEPTH_LOG2);

   fifo_pkg::addr_t  wptr;
   fifo_pkg::addr_t  rptr;
   fifo_pkg::level_t level_r;
   fifo_pkg::level_t level_nxt;
   logic             full_r;
   logic             empty_r;
   logic             wr_acc;
   logic             rd_acc;

   // ----------------------------------------
   // acceptance from our own flag registers
   // ----------------------------------------
   assign wr_acc = wr_req_i & ~full_r;
   assign rd_acc = rd_req_i & ~empty_r;

   // occupancy after this edge; both accepted leaves it unchanged
   always_comb begin
      case ({wr_acc, rd_acc})
         2'b10:   level_nxt = level_r + 1'b1;
         2'b01:   level_nxt = level_r - 1'b1;
         default: level_nxt = level_r;
      endcase
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wptr    <= '0;
         rptr    <= '0;
         level_r <= '0;
         full_r  <= 1'b0;
         empty_r <= 1'b1;
      end else begin
         // pointers wrap on their own at the depth
         if (wr_acc)
            wptr <= wptr + 1'b1;
         if (rd_acc)
            rptr <= rptr + 1'b1;
         level_r <= level_nxt;
         full_r  <= (level_nxt == DEPTH);
         empty_r <= (level_nxt == '0);
      end
   end

   // memory side
   assign mem_we_o    = wr_acc;
   assign mem_waddr_o = wptr;
   assign mem_re_o    = rd_acc;
   assign mem_raddr_o = rptr;

   // state for the flag generator
   assign occ.level  = level_r;
   assign occ.full   = full_r;
   assign occ.empty  = empty_r;
   assign occ.wr_req = wr_req_i;
   assign occ.rd_req = rd_req_i;
   assign occ.wr_acc = wr_acc;
   assign occ.rd_acc = rd_acc;

   // flags stay exclusive and level in range across any request mix
   a_flags_excl : assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(full_r && empty_r));
   a_level_max : assert property (@(posedge pos_clk) disable iff (!aresetn)
      level_r <= DEPTH);

endmodule

// File: hw/fifo_cfg_if.sv
/*
 * thresholds down from the register block, flags and error pulses up
 * pulses are one cycle wide
 */
`timescale 1ns/1ps

interface fifo_cfg_if;

   // programmed thresholds
   fifo_pkg::level_t afull_level;
   fifo_pkg::level_t aempty_level;

   // almost flags and error pulses
   logic afull;
   logic aempty;
   logic ovf_pulse;
   logic udf_pulse;

   // pass-through for the status word
   logic             full;
   logic             empty;
   fifo_pkg::level_t level;

   modport csr (
      output afull_level, aempty_level,
      input  afull, aempty, ovf_pulse, udf_pulse, full, empty, level
   );

   modport flags (
      input  afull_level, aempty_level,
      output afull, aempty, ovf_pulse, udf_pulse, full, empty, level
   );

endinterface

// File: hw/fifo_occ_if.sv
/*
 * occupancy and request state, pointer controller to flag generator
 * all flags are registered; acc signals are combinational in the current cycle
 */
`timescale 1ns/1ps

interface fifo_occ_if;

   // registered occupancy and flags
   fifo_pkg::level_t level;
   logic             full;
   logic             empty;

   // raw requests and what was accepted this cycle
   logic wr_req;
   logic rd_req;
   logic wr_acc;
   logic rd_acc;

   modport ctrl (
      output level, full, empty, wr_req, rd_req, wr_acc, rd_acc
   );

   modport flags (
      input level, full, empty, wr_req, rd_req, wr_acc, rd_acc
   );

endinterface

// File: hw/fifo_pkg.sv
/*
 * shared widths, register map and threshold reset values for the sync FIFO
 * depth is always a power of two; module parameters must match these defaults
 */
package fifo_pkg;

   // ----------------------------------------
   // sizes
   // ----------------------------------------
   localparam int DEPTH_LOG2 = 4;
   localparam int DATA_W     = 32;

   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [DEPTH_LOG2-1:0] addr_t;
   // one extra bit so a full FIFO is representable
   typedef logic [DEPTH_LOG2:0]   level_t;
   typedef logic [1:0]            wb_adr_t;

   // ----------------------------------------
   // register map, word addresses
   // ----------------------------------------
   localparam wb_adr_t REG_AFULL  = 2'd0;
   localparam wb_adr_t REG_AEMPTY = 2'd1;
   localparam wb_adr_t REG_STATUS = 2'd2;
   localparam wb_adr_t REG_ERR    = 2'd3;

   // threshold defaults
   localparam level_t AFULL_RST  = 5'd12;
   localparam level_t AEMPTY_RST = 5'd4;

   // status word layout
   localparam int ST_FULL      = 0;
   localparam int ST_EMPTY     = 1;
   localparam int ST_AFULL     = 2;
   localparam int ST_AEMPTY    = 3;
   localparam int ST_LEVEL_LSB = 8;

   // sticky error bits, write one to clear
   localparam int ERR_OVF = 0;
   localparam int ERR_UDF = 1;

endpackage
